// File: Makefile
TOP = digital_clock_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f digital_clock.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir \
		-f digital_clock.f
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "FAIL: run ended early, see $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

// File: digital_clock.f
verilog/clock_time_pkg.sv
verilog/display_pkg.sv
verilog/clock_ctrl_if.sv
verilog/tick_gen.sv
verilog/button_sync.sv
verilog/clock_controller.sv
verilog/hms_counter.sv
verilog/timekeeper.sv
verilog/seg_display.sv
verilog/digital_clock.sv
verif/digital_clock_sva.sv
verif/digital_clock_tb.sv

// File: verif/digital_clock_sva.sv
`timescale 1ns/1ps
`default_nettype none

module digital_clock_sva (
	input logic                     clk,
	input logic                     rst_n,
	input display_pkg::digit_sel_t  i_digit_sel,
	input logic                     i_seg_dp,
	input logic                     i_alarm,
	input clock_time_pkg::mode_t    i_mode,
	input logic                     i_alarm_en
);
	import clock_time_pkg::*;

	// One digit enabled at a time
	one_digit_enabled: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~i_digit_sel))
		else $error("Digit select %b does not enable exactly one digit", i_digit_sel);

	// Display outputs are registered and follow the mode one cycle late
	no_dp_in_clock_mode: assert property (@(posedge clk) disable iff (!rst_n)
		($past(i_mode) == MODE_CLOCK) |-> !i_seg_dp)
		else $error("Decimal point lit in clock mode");

	alarm_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(i_alarm_en) |-> !i_alarm)
		else $error("Alarm output high while alarm is disabled");

endmodule

bind digital_clock digital_clock_sva u_sva (
	.clk         (clk),
	.rst_n       (rst_n),
	.i_digit_sel (o_digit_sel),
	.i_seg_dp    (o_seg_dp),
	.i_alarm     (o_alarm),
	.i_mode      (ctrl_if.mode),
	.i_alarm_en  (ctrl_if.alarm_en)
);

`default_nettype wire

// File: verif/digital_clock_tb.sv
`timescale 1ns/1ps
`default_nettype none

module digital_clock_tb;
	import clock_time_pkg::*;
	import display_pkg::*;

	localparam int unsigned SEC_DIV    = 400;
	localparam int unsigned SAMPLE_DIV = 4;
	localparam int unsigned SCAN_DIV   = 2;
	localparam int TIMEOUT_CYCLES = 150 * SEC_DIV;	// About 40 s of tests plus margin
	localparam int BTN_MODE  = 0;
	localparam int BTN_POS   = 1;
	localparam int BTN_INC   = 2;
	localparam int BTN_ALARM = 3;

	logic       clk;
	logic       rst_n;
	logic [3:0] btn;		// {alarm, inc, pos, mode}
	seg_t       seg;
	digit_sel_t digit_sel;
	logic       seg_dp;
	logic       alarm;

	int    cycles = 0;
	mode_t cur_mode;		// Expected controller state
	pos_t  cur_pos;
	hms_t  time_val;
	hms_t  alarm_val;

	digital_clock #(
		.SEC_DIV    (SEC_DIV),
		.SAMPLE_DIV (SAMPLE_DIV),
		.SCAN_DIV   (SCAN_DIV)
	) digital_clock_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn[BTN_MODE]),
		.i_btn_pos   (btn[BTN_POS]),
		.i_btn_inc   (btn[BTN_INC]),
		.i_btn_alarm (btn[BTN_ALARM]),
		.o_seg       (seg),
		.o_digit_sel (digit_sel),
		.o_seg_dp    (seg_dp),
		.o_alarm     (alarm)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Error: the run timed out after %0d cycles", cycles);
			stop_with_failure();
		end
	end

	task automatic stop_with_failure();
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	// ----------------------------------------
	// Time helpers
	// ----------------------------------------
	function automatic int limit_of(pos_t p);
		case (p)
			POS_MIN: return MIN_MAX;
			POS_HOU: return HOU_MAX;
			default: return SEC_MAX;
		endcase
	endfunction

	function automatic int field_of(hms_t t, pos_t p);
		case (p)
			POS_MIN: return t.min;
			POS_HOU: return t.hou;
			default: return t.sec;
		endcase
	endfunction

	function automatic hms_t with_field(hms_t t, pos_t p, int v);
		hms_t r;
		r = t;
		case (p)
			POS_MIN: r.min = field_t'(v);
			POS_HOU: r.hou = field_t'(v);
			default: r.sec = field_t'(v);
		endcase
		return r;
	endfunction

	function automatic int to_secs(hms_t t);
		return t.hou * 3600 + t.min * 60 + t.sec;
	endfunction

	function automatic hms_t from_secs(int s);
		hms_t r;
		r.hou = field_t'(s / 3600);
		r.min = field_t'((s / 60) % 60);
		r.sec = field_t'(s % 60);
		return r;
	endfunction

	// Ones digit of the field, or its tens digit
	function automatic digit_sel_t cursor_mask(pos_t p, bit tens);
		int base;
		case (p)
			POS_MIN: base = 2;
			POS_HOU: base = 4;
			default: base = 0;
		endcase
		return digit_sel_t'(1) << (base + int'(tens));
	endfunction

	function automatic logic [3:0] seg_to_bcd(seg_t s);
		logic [3:0] v;
		int         i;
		v = 4'hf;			// No match
		for (i = 0; i < 10; i++) begin
			if (to_seg(4'(i)) == s)
				v = 4'(i);
		end
		return v;
	endfunction

	// ----------------------------------------
	// Display reader and compare tasks
	// ----------------------------------------
	task automatic read_display(output hms_t t, output digit_sel_t dp);
		logic [3:0] dig [NUM_DIGITS];
		digit_sel_t seen;
		int         idx;
		int         d;
		seen = '0;
		dp   = '0;
		while (seen != '1) begin
			@(negedge clk);
			idx = -1;
			for (d = 0; d < NUM_DIGITS; d++) begin
				if (digit_sel == ~(digit_sel_t'(1) << d))
					idx = d;
			end
			if (idx < 0 || seg_to_bcd(seg) > 4'd9) begin
				$display("Error: no valid digit on the display (select %b, segments %b)",
					digit_sel, seg);
				stop_with_failure();
			end else begin
				dig[idx]  = seg_to_bcd(seg);
				dp[idx]   = seg_dp;
				seen[idx] = 1'b1;
			end
		end
		t.sec = field_t'(dig[1] * 10 + dig[0]);
		t.min = field_t'(dig[3] * 10 + dig[2]);
		t.hou = field_t'(dig[5] * 10 + dig[4]);
	endtask

	task automatic check_time(string name, hms_t lo, hms_t hi, hms_t act);
		if (act.sec > SEC_MAX || act.min > MIN_MAX || act.hou > HOU_MAX ||
			to_secs(act) < to_secs(lo) || to_secs(act) > to_secs(hi)) begin
			$display("** Error %s: expected %0d:%0d:%0d to %0d:%0d:%0d, actual %0d:%0d:%0d",
				name, lo.hou, lo.min, lo.sec, hi.hou, hi.min, hi.sec,
				act.hou, act.min, act.sec);
			stop_with_failure();
		end
	endtask

	task automatic check_dp(string name, digit_sel_t exp, digit_sel_t act);
		if (act !== exp) begin
			$display("** Error %s: expected decimal points %b, actual %b", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_alarm(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("** Error %s: expected alarm %b, actual %b", name, exp, act);
			stop_with_failure();
		end
	endtask

	// ----------------------------------------
	// Buttons
	// ----------------------------------------
	task automatic press_button(int b);
		@(posedge clk);
		#1 btn[b] = 1'b1;
		repeat (20) @(posedge clk);
		#1 btn[b] = 1'b0;
		repeat (20) @(posedge clk);
		if (b == BTN_MODE)
			cur_mode = (cur_mode == MODE_CLOCK) ? MODE_SETUP :
				(cur_mode == MODE_SETUP) ? MODE_ALARM : MODE_CLOCK;
		else if (b == BTN_POS)
			cur_pos = (cur_pos == POS_SEC) ? POS_MIN :
				(cur_pos == POS_MIN) ? POS_HOU : POS_SEC;
	endtask

	task automatic press_inc(int n);
		repeat (n) press_button(BTN_INC);
	endtask

	task automatic select_pos(pos_t p);
		while (cur_pos != p)
			press_button(BTN_POS);
	endtask

	task automatic set_mode(mode_t m);
		while (cur_mode != m)
			press_button(BTN_MODE);
	endtask

	// Fields wrap without carry, so each one is stepped on its own
	task automatic set_fields(hms_t from, hms_t to);
		pos_t p;
		int   span;
		int   k;
		for (k = 0; k < 3; k++) begin
			p    = pos_t'(k);
			span = limit_of(p) + 1;
			select_pos(p);
			press_inc((field_of(to, p) - field_of(from, p) + span) % span);
		end
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic test_reset_state();
		hms_t       t;
		digit_sel_t dp;
		read_display(t, dp);
		check_time("reset_state", '0, '0, t);
		check_dp("reset_state", '0, dp);
		check_alarm("reset_state", 1'b0, alarm);
	endtask

	task automatic test_time_setting();
		hms_t       t;
		hms_t       exp;
		digit_sel_t dp;
		pos_t       p;
		int         k;
		int         n;
		set_mode(MODE_SETUP);		// Entered before the first second tick
		read_display(t, dp);
		check_time("time_setting entry", '0, '0, t);
		exp = '0;
		for (k = 0; k < 3; k++) begin
			p = pos_t'(k);
			select_pos(p);
			n = $urandom_range(limit_of(p) + 6, 0);	// Some counts pass the wrap
			press_inc(n);
			exp = with_field(exp, p, n % (limit_of(p) + 1));
			read_display(t, dp);
			check_time("time_setting", exp, exp, t);
			check_dp("time_setting", cursor_mask(p, 1'b0), dp);
		end
		repeat (3 * SEC_DIV) @(posedge clk);
		read_display(t, dp);
		check_time("time_setting frozen", exp, exp, t);
		time_val = exp;
	endtask

	task automatic test_running_carry();
		hms_t       t;
		hms_t       target;
		digit_sel_t dp;
		target = from_secs(23 * 3600 + 59 * 60 + 58);
		set_fields(time_val, target);
		read_display(t, dp);
		check_time("running_carry set", target, target, t);
		set_mode(MODE_CLOCK);
		repeat (5 * SEC_DIV) @(posedge clk);
		set_mode(MODE_SETUP);
		read_display(t, dp);
		check_time("running_carry", from_secs(1), from_secs(4), t);	// Allows for press latency
		time_val = t;
	endtask

	task automatic test_alarm_setting();
		hms_t       t;
		hms_t       exp;
		digit_sel_t dp;
		pos_t       p;
		int         k;
		int         start;
		int         elapsed;
		start = cycles;
		set_mode(MODE_ALARM);
		read_display(t, dp);
		check_time("alarm_setting entry", '0, '0, t);
		check_dp("alarm_setting entry", cursor_mask(cur_pos, 1'b1), dp);
		alarm_val.hou = field_t'($urandom_range(2, 0));
		alarm_val.min = field_t'($urandom_range(3, 1));
		alarm_val.sec = field_t'($urandom_range(50, 10));
		exp = '0;
		for (k = 0; k < 3; k++) begin
			p = pos_t'(k);
			select_pos(p);
			press_inc(field_of(alarm_val, p));
			exp = with_field(exp, p, field_of(alarm_val, p));
			read_display(t, dp);
			check_time("alarm_setting", exp, exp, t);
			check_dp("alarm_setting", cursor_mask(p, 1'b1), dp);
		end
		set_mode(MODE_SETUP);
		elapsed = (cycles - start) / SEC_DIV;
		// Time ran in alarm and clock modes, one second either way for press latency
		read_display(t, dp);
		check_time("alarm_setting time runs", from_secs(to_secs(time_val) + elapsed - 1),
			from_secs(to_secs(time_val) + elapsed + 1), t);
	endtask

	task automatic test_alarm_latch();
		hms_t       t;
		hms_t       now;
		hms_t       target;
		digit_sel_t dp;
		int         n;
		read_display(now, dp);
		target = from_secs(to_secs(alarm_val) - 3);
		set_fields(now, target);
		read_display(t, dp);
		check_time("alarm_latch set", target, target, t);
		set_mode(MODE_CLOCK);
		press_button(BTN_ALARM);	// Enable
		@(negedge clk);
		check_alarm("alarm_latch armed", 1'b0, alarm);
		n = 0;
		while (!alarm && n < 5 * SEC_DIV) begin
			@(negedge clk);
			n++;
		end
		check_alarm("alarm_latch rise", 1'b1, alarm);
		repeat (3 * SEC_DIV) begin
			@(negedge clk);
			check_alarm("alarm_latch hold", 1'b1, alarm);
		end
		press_button(BTN_ALARM);	// Disable
		@(negedge clk);
		check_alarm("alarm_latch clear", 1'b0, alarm);
	endtask

	initial begin
		void'($urandom(32'hb706_8805));
		rst_n    = 1'b0;
		btn      = '0;
		cur_mode = MODE_CLOCK;
		cur_pos  = POS_SEC;
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;
		repeat (2) @(posedge clk);
		test_reset_state();
		test_time_setting();
		test_running_carry();
		test_alarm_setting();
		test_alarm_latch();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/button_sync.sv
`timescale 1ns/1ps
`default_nettype none

module button_sync (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_sample,
	input  logic [3:0] i_btn,	// {alarm, inc, pos, mode}
	output logic [3:0] o_press
);

	logic [3:0] sync_q1;
	logic [3:0] sync_q2;
	logic [3:0] sample_q;		// Level at the previous sample

	// ----------------------------------------
	// Two-flop synchronizer
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= i_btn;
			sync_q2 <= sync_q1;
		end
	end

	// Sampling at the debounce rate filters bounce shorter than a period
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_q <= '0;
			o_press  <= '0;
		end else if (i_sample) begin
			sample_q <= sync_q2;
			o_press  <= sync_q2 & ~sample_q;	// Rising level between samples
		end else begin
			o_press  <= '0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/clock_controller.sv
`timescale 1ns/1ps
`default_nettype none

module clock_controller (
	input  logic         clk,
	input  logic         rst_n,
	input  logic [3:0]   i_press,	// {alarm, inc, pos, mode}
	clock_ctrl_if.ctrl   o_ctrl
);
	import clock_time_pkg::*;

	mode_t mode_q;
	pos_t  pos_q;
	logic  inc_q;
	logic  alarm_en_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q     <= MODE_CLOCK;
			pos_q      <= POS_SEC;
			inc_q      <= 1'b0;
			alarm_en_q <= 1'b0;
		end else begin
			if (i_press[0]) begin		// Mode button
				case (mode_q)
					MODE_CLOCK: mode_q <= MODE_SETUP;
					MODE_SETUP: mode_q <= MODE_ALARM;
					default:    mode_q <= MODE_CLOCK;
				endcase
			end

			if (i_press[1]) begin		// Position button
				case (pos_q)
					POS_SEC: pos_q <= POS_MIN;
					POS_MIN: pos_q <= POS_HOU;
					default: pos_q <= POS_SEC;
				endcase
			end

			inc_q <= i_press[2];

			if (i_press[3])
				alarm_en_q <= ~alarm_en_q;	// Toggle
		end
	end

	assign o_ctrl.mode     = mode_q;
	assign o_ctrl.pos      = pos_q;
	assign o_ctrl.inc      = inc_q;
	assign o_ctrl.alarm_en = alarm_en_q;

endmodule

`default_nettype wire

// File: verilog/clock_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface clock_ctrl_if;
	import clock_time_pkg::*;

	mode_t mode;
	pos_t  pos;
	logic  inc;		// One-cycle strobe
	logic  alarm_en;	// Level

	modport ctrl (output mode, output pos, output inc, output alarm_en);

	modport keeper (input mode, input pos, input inc, input alarm_en);

	// Display only needs the cursor
	modport disp (input mode, input pos);

endinterface

`default_nettype wire

// File: verilog/clock_time_pkg.sv
`default_nettype none

package clock_time_pkg;

	// ----------------------------------------
	// Time fields
	// ----------------------------------------
	typedef logic [5:0] field_t;		// 0 to 59

	typedef struct packed {
		field_t hou;
		field_t min;
		field_t sec;
	} hms_t;

	localparam field_t SEC_MAX = 6'd59;
	localparam field_t MIN_MAX = 6'd59;
	localparam field_t HOU_MAX = 6'd23;

	// ----------------------------------------
	// Operating modes and cursor
	// ----------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,		// Time frozen, fields editable
		MODE_ALARM = 2'd2		// Alarm fields editable, time runs
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HOU = 2'd2
	} pos_t;

	// Divider counts for a 50 MHz clk
	localparam int unsigned SEC_DIV_DEF    = 50_000_000;	// 1 Hz
	localparam int unsigned SAMPLE_DIV_DEF = 500_000;	// 100 Hz button sampling
	localparam int unsigned SCAN_DIV_DEF   = 5_000;		// 10 kHz digit scan

endpackage

`default_nettype wire

// File: verilog/digital_clock.sv
`timescale 1ns/1ps
`default_nettype none

module digital_clock #(
	parameter int unsigned SEC_DIV    = clock_time_pkg::SEC_DIV_DEF,
	parameter int unsigned SAMPLE_DIV = clock_time_pkg::SAMPLE_DIV_DEF,
	parameter int unsigned SCAN_DIV   = clock_time_pkg::SCAN_DIV_DEF
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_btn_mode,
	input  logic       i_btn_pos,
	input  logic       i_btn_inc,
	input  logic       i_btn_alarm,
	output logic [6:0] o_seg,
	output logic [5:0] o_digit_sel,
	output logic       o_seg_dp,
	output logic       o_alarm
);
	import clock_time_pkg::*;

	logic       sec_tick;
	logic       sample_tick;
	logic       scan_tick;
	logic [3:0] press;
	hms_t       disp_time;

	clock_ctrl_if ctrl_if ();

	// ----------------------------------------
	// Enable strobes
	// ----------------------------------------
	tick_gen #(.DIVISOR(SEC_DIV)) u_sec_tick (
		.clk (clk), .rst_n (rst_n), .o_tick (sec_tick)
	);

	tick_gen #(.DIVISOR(SAMPLE_DIV)) u_sample_tick (
		.clk (clk), .rst_n (rst_n), .o_tick (sample_tick)
	);

	tick_gen #(.DIVISOR(SCAN_DIV)) u_scan_tick (
		.clk (clk), .rst_n (rst_n), .o_tick (scan_tick)
	);

	button_sync u_button_sync (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_sample (sample_tick),
		.i_btn    ({i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode}),
		.o_press  (press)
	);

	clock_controller u_clock_controller (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_press (press),
		.o_ctrl  (ctrl_if)
	);

	timekeeper u_timekeeper (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sec_tick  (sec_tick),
		.i_ctrl      (ctrl_if),
		.o_disp_time (disp_time),
		.o_alarm     (o_alarm)
	);

	seg_display u_seg_display (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan      (scan_tick),
		.i_disp_time (disp_time),
		.i_ctrl      (ctrl_if),
		.o_seg       (o_seg),
		.o_digit_sel (o_digit_sel),
		.o_seg_dp    (o_seg_dp)
	);

endmodule

`default_nettype wire

// File: verilog/display_pkg.sv
`default_nettype none

package display_pkg;

	localparam int NUM_DIGITS = 6;

	typedef logic [6:0] seg_t;			// {a, b, c, d, e, f, g}, active high
	typedef logic [NUM_DIGITS-1:0] digit_sel_t;	// Active low, bit 0 is seconds ones
	typedef logic [$clog2(NUM_DIGITS)-1:0] digit_idx_t;

	// BCD digit to segment pattern
	function automatic seg_t to_seg(logic [3:0] bcd);
		case (bcd)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;	// Blank
		endcase
	endfunction

	function automatic logic [3:0] tens_of(clock_time_pkg::field_t f);
		return 4'(f / 6'd10);
	endfunction

	function automatic logic [3:0] ones_of(clock_time_pkg::field_t f);
		return 4'(f % 6'd10);
	endfunction

endpackage

`default_nettype wire

// File: verilog/hms_counter.sv
`timescale 1ns/1ps
`default_nettype none

module hms_counter (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_tick,	// Advance one second with carry
	input  logic                  i_inc,	// Bump the selected field only
	input  clock_time_pkg::pos_t  i_pos,
	output clock_time_pkg::hms_t  o_time
);
	import clock_time_pkg::*;

	hms_t cnt_q;

	// Add one, back to zero past the limit
	function automatic field_t wrap_inc(field_t f, field_t lim);
		return (f >= lim) ? '0 : f + 1'b1;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= '0;
		end else if (i_tick) begin
			cnt_q.sec <= wrap_inc(cnt_q.sec, SEC_MAX);
			if (cnt_q.sec >= SEC_MAX) begin
				cnt_q.min <= wrap_inc(cnt_q.min, MIN_MAX);	// Carry into minutes
				if (cnt_q.min >= MIN_MAX)
					cnt_q.hou <= wrap_inc(cnt_q.hou, HOU_MAX);
			end
		end else if (i_inc) begin
			// ----------------------------------------
			// Setting, no carry between fields
			// ----------------------------------------
			case (i_pos)
				POS_SEC: begin
					cnt_q.sec <= wrap_inc(cnt_q.sec, SEC_MAX);
				end
				POS_MIN: begin
					cnt_q.min <= wrap_inc(cnt_q.min, MIN_MAX);
				end
				POS_HOU: begin
					cnt_q.hou <= wrap_inc(cnt_q.hou, HOU_MAX);
				end
				default: begin
					cnt_q <= cnt_q;
				end
			endcase
		end
	end

	assign o_time = cnt_q;

endmodule

`default_nettype wire

// File: verilog/seg_display.sv
`timescale 1ns/1ps
`default_nettype none

module seg_display (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      i_scan,
	input  clock_time_pkg::hms_t      i_disp_time,
	clock_ctrl_if.disp                i_ctrl,
	output display_pkg::seg_t         o_seg,
	output display_pkg::digit_sel_t   o_digit_sel,
	output logic                      o_seg_dp
);
	import clock_time_pkg::*;
	import display_pkg::*;

	logic [3:0] digits [NUM_DIGITS];
	digit_idx_t scan_idx;
	digit_idx_t field_base;		// Ones digit of the selected field
	digit_sel_t dp_mask;

	// ----------------------------------------
	// Digit split, seconds ones first
	// ----------------------------------------
	assign digits[0] = ones_of(i_disp_time.sec);
	assign digits[1] = tens_of(i_disp_time.sec);
	assign digits[2] = ones_of(i_disp_time.min);
	assign digits[3] = tens_of(i_disp_time.min);
	assign digits[4] = ones_of(i_disp_time.hou);
	assign digits[5] = tens_of(i_disp_time.hou);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			scan_idx <= '0;
		else if (i_scan)
			scan_idx <= (scan_idx == digit_idx_t'(NUM_DIGITS - 1)) ? '0 : scan_idx + 1'b1;
	end

	// Cursor: ones digit in setup, tens digit in alarm
	always_comb begin
		case (i_ctrl.pos)
			POS_MIN: field_base = digit_idx_t'(2);
			POS_HOU: field_base = digit_idx_t'(4);
			default: field_base = '0;
		endcase

		dp_mask = '0;
		if (i_ctrl.mode == MODE_SETUP)
			dp_mask[field_base] = 1'b1;
		else if (i_ctrl.mode == MODE_ALARM)
			dp_mask[field_base + 1'b1] = 1'b1;
	end

	// ----------------------------------------
	// Registered outputs
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg       <= '0;
			o_digit_sel <= ~digit_sel_t'(1);	// Digit 0 enabled
			o_seg_dp    <= 1'b0;
		end else begin
			o_seg       <= to_seg(digits[scan_idx]);
			o_digit_sel <= ~(digit_sel_t'(1) << scan_idx);
			o_seg_dp    <= dp_mask[scan_idx];
		end
	end

endmodule

`default_nettype wire

// File: verilog/tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
	parameter int unsigned DIVISOR = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int unsigned CNT_W = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;

	logic [CNT_W-1:0] cnt;		// Cycles left until the next strobe

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= CNT_W'(DIVISOR - 1);
			o_tick <= 1'b0;
		end else if (cnt == '0) begin
			cnt    <= CNT_W'(DIVISOR - 1);	// Reload
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt - 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/timekeeper.sv
`timescale 1ns/1ps
`default_nettype none

module timekeeper (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_sec_tick,
	clock_ctrl_if.keeper          i_ctrl,
	output clock_time_pkg::hms_t  o_disp_time,
	output logic                  o_alarm
);
	import clock_time_pkg::*;

	hms_t cur_time;
	hms_t alarm_time;
	logic time_tick;
	logic time_inc;
	logic alarm_inc;

	// Time is frozen while being set
	assign time_tick = i_sec_tick &
		((i_ctrl.mode == MODE_CLOCK) || (i_ctrl.mode == MODE_ALARM));
	assign time_inc  = i_ctrl.inc & (i_ctrl.mode == MODE_SETUP);
	assign alarm_inc = i_ctrl.inc & (i_ctrl.mode == MODE_ALARM);

	hms_counter u_time (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_tick (time_tick),
		.i_inc  (time_inc),
		.i_pos  (i_ctrl.pos),
		.o_time (cur_time)
	);

	hms_counter u_alarm (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_tick (1'b0),		// Alarm time never runs
		.i_inc  (alarm_inc),
		.i_pos  (i_ctrl.pos),
		.o_time (alarm_time)
	);

	assign o_disp_time = (i_ctrl.mode == MODE_ALARM) ? alarm_time : cur_time;

	// Latch on match, hold until disabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else if (!i_ctrl.alarm_en)
			o_alarm <= 1'b0;
		else if (cur_time == alarm_time)
			o_alarm <= 1'b1;
	end

endmodule

`default_nettype wire
